//--- common/srt_settings.svh
/* Width and depth settings for the sort-engine sequencer
   Included by every file that sizes a bus, a store or an array */
`ifndef SRT_SETTINGS_SVH
`define SRT_SETTINGS_SVH

// Datapath word width
`define SRT_W 16

// Program counter width
// Also sets the microcode store depth
`define SRT_PC_W 8

// Architectural register count
// Last register acts as link
`define SRT_REG_N 8

// Hardware stack depth in words
// Kept a power of two
`define SRT_STACK_N 16

// Immediate and jump target field width
`define SRT_IMM_W 8

`endif

//--- common/srt_pkg.sv
/* Shared types of the sort-engine sequencer
   Opcodes, condition codes, instruction layout, decoded controls and flags */
`include "srt_settings.svh"

package srt_pkg;

  // Register index
  typedef logic [$clog2(`SRT_REG_N)-1:0] reg_t;

  // Link register written by CALL and read by RET
  localparam reg_t REG_LINK = reg_t'(`SRT_REG_N - 1);

  // Operation field
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,
    SUB   = 4'd2,
    ADDI  = 4'd3,
    CMP   = 4'd4,
    LDN   = 4'd5,
    J     = 4'd6,
    CALL  = 4'd7,
    RET   = 4'd8,
    PUSH  = 4'd9,
    POP   = 4'd10,
    ST    = 4'd11,
    AWAIT = 4'd12,
    DONE  = 4'd13
  } opcode_e;

  // Jump conditions on the architectural flags
  typedef enum logic [1:0] {
    AL = 2'd0,
    EQ = 2'd1,
    GT = 2'd2,
    LE = 2'd3
  } cc_e;

  // Instruction word
  // imm doubles as the target PC of J and CALL
  typedef struct packed {
    opcode_e               opcode;
    cc_e                   cc;
    reg_t                  dst;
    reg_t                  src0;
    reg_t                  src1;
    logic [`SRT_IMM_W-1:0] imm;
  } inst_t;

  // Decoded controls for the execute stage
  typedef struct packed {
    logic                  dst_en;
    reg_t                  dst;
    reg_t                  src0;
    reg_t                  src1;
    logic                  has_imm;
    logic                  is_special_n;
    logic                  inv_src1;
    logic                  cin;
    logic                  flag_en;
    logic                  is_jump;
    cc_e                   cc;
    logic                  is_call;
    logic                  is_ret;
    logic                  is_push;
    logic                  is_pop;
    logic                  is_store;
    logic                  is_await;
    logic                  is_done;
    // Immediate operand or jump target
    logic [`SRT_IMM_W-1:0] target;
  } ucode_t;

  // Carry, negative and zero
  typedef struct packed {
    logic c;
    logic n;
    logic z;
  } flags_t;

endpackage

//--- common/srt_fe_if.sv
/* Fetch to execute link of the sequencer pipeline
   Fetch hands over instructions, execute returns stall, replay and halt */
`timescale 1ns/1ps
`include "srt_settings.svh"

interface srt_fe_if;

  // FA instruction towards XA
  logic                  inst_vld;
  srt_pkg::inst_t        inst;
  logic [`SRT_PC_W-1:0]  pc;

  // Pipeline control back from XA
  logic                  stall;
  logic                  replay;
  logic [`SRT_PC_W-1:0]  replay_pc;
  logic                  halt;

  modport fetch (
    output inst_vld, inst, pc,
    input  stall, replay, replay_pc, halt
  );

  modport exec (
    input  inst_vld, inst, pc,
    output stall, replay, replay_pc, halt
  );

endinterface

//--- common/srt_stack_if.sv
/* Command and status link between the execute stage and the stack
   A command with cmd_vld high is applied on that cycle's clock edge */
`timescale 1ns/1ps
`include "srt_settings.svh"

interface srt_stack_if;

  // Command from XA
  logic              cmd_vld;
  // High for PUSH, low for POP
  logic              push;
  logic [`SRT_W-1:0] push_dat;

  // Current top of stack and fill levels
  logic [`SRT_W-1:0] head;
  logic              empty;
  logic              full;

  modport exec (
    output cmd_vld, push, push_dat,
    input  head, empty, full
  );

  modport stack (
    input  cmd_vld, push, push_dat,
    output head, empty, full
  );

endinterface

//--- verilog/srt_fetch.sv
/* Fetch stage (FA) with the run flag, PC and writable microcode store
   Program is loaded while idle, a start pulse runs it from PC 0 */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_fetch (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 prog_we,
  input  logic [`SRT_PC_W-1:0] prog_addr,
  input  srt_pkg::inst_t       prog_data,
  input  logic                 start,
  output logic                 busy,
  srt_fe_if.fetch              fe
);

  logic                 run_q;
  logic                 fa_vld;
  logic                 fa_adv;
  logic [`SRT_PC_W-1:0] pc_q;
  srt_pkg::inst_t       ucode_mem [2**`SRT_PC_W];

  // FA is killed by replay and by halt
  assign fa_vld = run_q & ~fe.replay & ~fe.halt;
  // Moves into XA unless AWAIT holds the pipe
  assign fa_adv = fa_vld & ~fe.stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q <= 1'b0;
      pc_q  <= '0;
    end else if (start && !run_q) begin
      // Start runs from the first word
      run_q <= 1'b1;
      pc_q  <= '0;
    end else begin
      if (fe.halt) begin
        run_q <= 1'b0;
      end
      // Replay target wins over sequential fetch
      if (fe.replay) begin
        pc_q <= fe.replay_pc;
      end else if (fa_adv) begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  // Program port write
  always_ff @(posedge clk) begin
    if (prog_we) begin
      ucode_mem[prog_addr] <= prog_data;
    end
  end

  // Asynchronous read at the current PC
  assign fe.inst     = ucode_mem[pc_q];
  assign fe.inst_vld = fa_vld;
  assign fe.pc       = pc_q;

  // Drops in the same cycle as the done pulse
  assign busy = run_q & ~fe.halt;

  // Store must not change under a running program
  a_no_prog_while_busy : assert property (
    @(posedge clk) disable iff (!arst_n) prog_we |-> !run_q
  );

endmodule

//--- exec/srt_decoder.sv
/* Instruction decoder of the execute stage
   Maps each opcode onto the control bits used by the XA datapath */
`timescale 1ns/1ps

module srt_decoder (
  input  srt_pkg::inst_t  inst,
  output srt_pkg::ucode_t ucode
);

  always_comb begin
    // Fields pass through, controls default off
    ucode        = '0;
    ucode.dst    = inst.dst;
    ucode.src0   = inst.src0;
    ucode.src1   = inst.src1;
    ucode.cc     = srt_pkg::AL;
    ucode.target = inst.imm;

    case (inst.opcode)
      srt_pkg::ADD: begin
        ucode.dst_en  = 1'b1;
        ucode.flag_en = 1'b1;
      end
      srt_pkg::SUB: begin
        // src0 + ~src1 + 1
        ucode.dst_en   = 1'b1;
        ucode.flag_en  = 1'b1;
        ucode.inv_src1 = 1'b1;
        ucode.cin      = 1'b1;
      end
      srt_pkg::ADDI: begin
        ucode.dst_en  = 1'b1;
        ucode.flag_en = 1'b1;
        ucode.has_imm = 1'b1;
      end
      srt_pkg::CMP: begin
        // Subtract for flags only
        ucode.flag_en  = 1'b1;
        ucode.inv_src1 = 1'b1;
        ucode.cin      = 1'b1;
      end
      srt_pkg::LDN: begin
        // r0 + N
        ucode.dst_en       = 1'b1;
        ucode.is_special_n = 1'b1;
        ucode.src0         = '0;
      end
      srt_pkg::J: begin
        ucode.is_jump = 1'b1;
        ucode.cc      = inst.cc;
      end
      srt_pkg::CALL: begin
        // Link PC+1 goes to r7
        ucode.is_call = 1'b1;
        ucode.dst_en  = 1'b1;
        ucode.dst     = srt_pkg::REG_LINK;
      end
      srt_pkg::RET: begin
        ucode.is_ret = 1'b1;
        ucode.src1   = srt_pkg::REG_LINK;
      end
      srt_pkg::PUSH:  ucode.is_push = 1'b1;
      srt_pkg::POP: begin
        ucode.is_pop = 1'b1;
        ucode.dst_en = 1'b1;
      end
      srt_pkg::ST:    ucode.is_store = 1'b1;
      srt_pkg::AWAIT: ucode.is_await = 1'b1;
      srt_pkg::DONE:  ucode.is_done  = 1'b1;
      // NOP and unused encodings do nothing
      default: ;
    endcase
  end

endmodule

//--- exec/srt_regfile.sv
/* Architectural register file with two asynchronous read ports
   Register 0 always reads as zero, one write port from commit */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_regfile (
  input  logic              clk,
  input  logic              arst_n,
  input  srt_pkg::reg_t     ra0,
  input  srt_pkg::reg_t     ra1,
  output logic [`SRT_W-1:0] rdata0,
  output logic [`SRT_W-1:0] rdata1,
  input  logic              wen,
  input  srt_pkg::reg_t     wa,
  input  logic [`SRT_W-1:0] wdata
);

  logic [`SRT_W-1:0] regs_q [`SRT_REG_N];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs_q <= '{default: '0};
    end else if (wen) begin
      regs_q[wa] <= wdata;
    end
  end

  // Zero register
  assign rdata0 = (ra0 == '0) ? '0 : regs_q[ra0];
  assign rdata1 = (ra1 == '0) ? '0 : regs_q[ra1];

endmodule

//--- exec/srt_exec.sv
/* Execute/commit stage (XA) with ALU, flags, branches, stack and bank control
   Commits each instruction in XA and registers its writeback for CA */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_exec (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              bank_ready,
  input  logic [`SRT_W-1:0] bank_n,
  output logic              done,
  output logic              bank_sorting,
  output logic              srt_wr_en,
  output logic [`SRT_W-1:0] srt_wr_addr,
  output logic [`SRT_W-1:0] srt_wr_data,
  srt_fe_if.exec            fe,
  srt_stack_if.exec         stk
);

  logic                 xa_vld_q;
  srt_pkg::inst_t       xa_inst_q;
  logic [`SRT_PC_W-1:0] xa_pc_q;
  srt_pkg::ucode_t      uc;
  logic                 xa_kill;
  logic                 xa_stall;
  logic                 xa_commit;
  logic                 cc_hit;
  logic                 fwd0;
  logic                 fwd1;
  logic [`SRT_W-1:0]    rdata0;
  logic [`SRT_W-1:0]    rdata1;
  logic [`SRT_W-1:0]    opa;
  logic [`SRT_W-1:0]    opb_pre;
  logic [`SRT_W-1:0]    opb;
  logic [`SRT_W-1:0]    alu_y;
  logic                 alu_cout;
  logic [`SRT_PC_W-1:0] link_pc;
  logic                 ca_wen_q;
  srt_pkg::reg_t        ca_wa_q;
  logic [`SRT_W-1:0]    ca_wdata_q;
  logic [`SRT_W-1:0]    ca_wdata_w;
  srt_pkg::flags_t      flags_q;
  logic                 replay_w;
  logic                 replay_q;
  logic [`SRT_PC_W-1:0] replay_pc_w;
  logic [`SRT_PC_W-1:0] replay_pc_q;

  srt_decoder decoder_inst (
    .inst  (xa_inst_q),
    .ucode (uc)
  );

  srt_regfile regfile_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .ra0    (uc.src0),
    .ra1    (uc.src1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (ca_wen_q),
    .wa     (ca_wa_q),
    .wdata  (ca_wdata_q)
  );

  // Pipe control
  // Replay and halt flush the younger instruction in XA
  assign xa_kill   = replay_q | done;
  assign xa_stall  = xa_vld_q & ~xa_kill & uc.is_await & ~bank_ready;
  assign xa_commit = xa_vld_q & ~xa_kill & ~xa_stall;

  always_comb begin
    // CA to XA forwarding, r0 is never written
    fwd0 = ca_wen_q & (uc.src0 == ca_wa_q);
    fwd1 = ca_wen_q & (uc.src1 == ca_wa_q);
    opa  = fwd0 ? ca_wdata_q : rdata0;

    // Operand B from N, immediate or register
    if (uc.is_special_n) begin
      opb_pre = bank_n;
    end else if (uc.has_imm) begin
      opb_pre = {{(`SRT_W-`SRT_IMM_W){1'b0}}, uc.target};
    end else if (fwd1) begin
      opb_pre = ca_wdata_q;
    end else begin
      opb_pre = rdata1;
    end
    opb = opb_pre ^ {`SRT_W{uc.inv_src1}};
    {alu_cout, alu_y} = {1'b0, opa} + {1'b0, opb} + {{`SRT_W{1'b0}}, uc.cin};

    case (uc.cc)
      srt_pkg::EQ: cc_hit = flags_q.z;
      srt_pkg::GT: cc_hit = ~flags_q.z & ~flags_q.n;
      srt_pkg::LE: cc_hit = flags_q.z | flags_q.n;
      default:     cc_hit = 1'b1;
    endcase

    // Writeback source
    link_pc = xa_pc_q + 1'b1;
    if (uc.is_pop) begin
      ca_wdata_w = stk.head;
    end else if (uc.is_call) begin
      ca_wdata_w = {{(`SRT_W-`SRT_PC_W){1'b0}}, link_pc};
    end else begin
      ca_wdata_w = alu_y;
    end

    // Flow change, RET takes r7 through operand B
    replay_w    = xa_commit & ((uc.is_jump & cc_hit) | uc.is_call | uc.is_ret);
    replay_pc_w = uc.is_ret ? opb_pre[`SRT_PC_W-1:0] : `SRT_PC_W'(uc.target);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      xa_vld_q     <= 1'b0;
      ca_wen_q     <= 1'b0;
      flags_q      <= '0;
      replay_q     <= 1'b0;
      done         <= 1'b0;
      bank_sorting <= 1'b0;
      srt_wr_en    <= 1'b0;
    end else begin
      if (!xa_stall) begin
        xa_vld_q <= fe.inst_vld;
      end
      ca_wen_q <= xa_commit & uc.dst_en & (uc.dst != '0);
      if (xa_commit && uc.flag_en) begin
        flags_q <= '{c: alu_cout, n: alu_y[`SRT_W-1], z: (alu_y == '0)};
      end
      replay_q  <= replay_w;
      done      <= xa_commit & uc.is_done;
      srt_wr_en <= xa_commit & uc.is_store;
      // Bank owned from AWAIT until DONE
      if (xa_commit && uc.is_await) begin
        bank_sorting <= 1'b1;
      end else if (xa_commit && uc.is_done) begin
        bank_sorting <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fe.inst_vld && !xa_stall) begin
      xa_inst_q <= fe.inst;
      xa_pc_q   <= fe.pc;
    end
    ca_wa_q    <= uc.dst;
    ca_wdata_q <= ca_wdata_w;
    if (replay_w) begin
      replay_pc_q <= replay_pc_w;
    end
    // Store address from src0, data from src1
    if (xa_commit && uc.is_store) begin
      srt_wr_addr <= opa;
      srt_wr_data <= opb_pre;
    end
  end

  assign fe.stall     = xa_stall;
  assign fe.replay    = replay_q;
  assign fe.replay_pc = replay_pc_q;
  assign fe.halt      = done;

  // Stack command at commit, applied on this edge
  assign stk.cmd_vld  = xa_commit & (uc.is_push | uc.is_pop);
  assign stk.push     = uc.is_push;
  assign stk.push_dat = opb_pre;

  a_no_push_full : assert property (
    @(posedge clk) disable iff (!arst_n) (stk.cmd_vld && stk.push) |-> !stk.full
  );

  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!arst_n) (stk.cmd_vld && !stk.push) |-> !stk.empty
  );

endmodule

//--- verilog/srt_stack.sv
/* Hardware LIFO for PUSH and POP with a combinational head
   Overflowing or underflowing commands leave the stack unchanged */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_stack (
  input logic        clk,
  input logic        arst_n,
  srt_stack_if.stack stk
);

  // One spare bit so the pointer reaches the full count
  localparam int PTR_W = $clog2(`SRT_STACK_N) + 1;

  logic [PTR_W-1:0]  ptr_q;
  logic [PTR_W-2:0]  top_idx;
  logic              do_push;
  logic              do_pop;
  logic [`SRT_W-1:0] mem [`SRT_STACK_N];

  assign stk.empty = (ptr_q == '0);
  assign stk.full  = (ptr_q == PTR_W'(`SRT_STACK_N));

  // Top entry sits just below the pointer
  assign top_idx  = ptr_q[PTR_W-2:0] - 1'b1;
  assign stk.head = mem[top_idx];

  assign do_push = stk.cmd_vld & stk.push & ~stk.full;
  assign do_pop  = stk.cmd_vld & ~stk.push & ~stk.empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q <= '0;
    end else if (do_push) begin
      ptr_q <= ptr_q + 1'b1;
    end else if (do_pop) begin
      ptr_q <= ptr_q - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[ptr_q[PTR_W-2:0]] <= stk.push_dat;
    end
  end

endmodule

//--- verilog/srt_core.sv
/* Top level of the sort-engine sequencer core
   Joins fetch, execute and stack, exposes program, bank and write ports */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_core (
  input  logic                 clk,
  input  logic                 arst_n,
  // Microcode load
  input  logic                 prog_we,
  input  logic [`SRT_PC_W-1:0] prog_addr,
  input  srt_pkg::inst_t       prog_data,
  // Run control
  input  logic                 start,
  input  logic                 bank_ready,
  input  logic [`SRT_W-1:0]    bank_n,
  output logic                 busy,
  output logic                 done,
  output logic                 bank_sorting,
  // Bank write port
  output logic                 srt_wr_en,
  output logic [`SRT_W-1:0]    srt_wr_addr,
  output logic [`SRT_W-1:0]    srt_wr_data
);

  srt_fe_if    fe_if_inst ();
  srt_stack_if stk_if_inst ();

  srt_fetch fetch_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .start     (start),
    .busy      (busy),
    .fe        (fe_if_inst)
  );

  srt_exec exec_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .bank_ready   (bank_ready),
    .bank_n       (bank_n),
    .done         (done),
    .bank_sorting (bank_sorting),
    .srt_wr_en    (srt_wr_en),
    .srt_wr_addr  (srt_wr_addr),
    .srt_wr_data  (srt_wr_data),
    .fe           (fe_if_inst),
    .stk          (stk_if_inst)
  );

  srt_stack stack_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .stk    (stk_if_inst)
  );

endmodule

//--- dv/srt_tests.svh
/* Directed tests of the sequencer with one task per behavior
   Included inside the testbench module and uses its helper tasks */
`ifndef SRT_TESTS_SVH
`define SRT_TESTS_SVH

task automatic check_reset_idle();
  @(negedge clk);
  check_eq(busy, 1'b0, "busy after reset");
  check_eq(done, 1'b0, "done after reset");
  check_eq(bank_sorting, 1'b0, "bank_sorting after reset");
  check_eq(srt_wr_en, 1'b0, "srt_wr_en after reset");
endtask

// Dependent ALU chain with 16-bit wrap-around
task automatic alu_forwarding();
  logic [`SRT_W-1:0] v1;
  logic [`SRT_W-1:0] v2;
  logic [`SRT_W-1:0] v3;
  logic [`SRT_W-1:0] v4;
  logic [`SRT_W-1:0] v5;
  v1 = 16'd100;
  v2 = v1 + 16'd200;
  v3 = v2 + v1;
  v4 = v1 - v3;
  v5 = v4 + v4;
  prog_q.delete();
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd1, 3'd0, 3'd0, 8'd100);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd2, 3'd1, 3'd0, 8'd200);
  append_inst(srt_pkg::ADD,  srt_pkg::AL, 3'd3, 3'd2, 3'd1, 8'd0);
  append_inst(srt_pkg::SUB,  srt_pkg::AL, 3'd4, 3'd1, 3'd3, 8'd0);
  append_inst(srt_pkg::ADD,  srt_pkg::AL, 3'd5, 3'd4, 3'd4, 8'd0);
  // Store right behind its producer
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd5, 8'd0);
  // Write to r0 must vanish
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd0, 3'd5, 3'd0, 8'd7);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd1, 3'd2, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd3, 3'd4, 8'd0);
  append_inst(srt_pkg::DONE, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  expect_store(16'd0, v5);
  expect_store(16'd0, 16'd0);
  expect_store(v1, v2);
  expect_store(v3, v4);
  load_program();
  start_core();
  wait_done("alu_forwarding", 1'b0);
  compare_stores("alu_forwarding");
endtask

// Counter loop bounded by N with exits through GT, EQ and LE
task automatic branch_count_loop();
  int rnd;
  int n_cnt;
  rnd   = $random(seed);
  n_cnt = (rnd & 7) + 1;
  @(posedge clk);
  #DRIVE_DLY bank_n = `SRT_W'(n_cnt);
  prog_q.delete();
  append_inst(srt_pkg::LDN,  srt_pkg::AL, 3'd1, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd2, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd3, 3'd0, 3'd0, 8'd1);
  // Loop head at 3
  append_inst(srt_pkg::ADD,  srt_pkg::AL, 3'd2, 3'd2, 3'd3, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd2, 3'd2, 8'd0);
  append_inst(srt_pkg::CMP,  srt_pkg::AL, 3'd0, 3'd1, 3'd2, 8'd0);
  append_inst(srt_pkg::J,    srt_pkg::GT, 3'd0, 3'd0, 3'd0, 8'd3);
  append_inst(srt_pkg::J,    srt_pkg::EQ, 3'd0, 3'd0, 3'd0, 8'd9);
  // Reached only on a wrong EQ
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd3, 8'd0);
  // 1 - N is zero or negative
  append_inst(srt_pkg::CMP,  srt_pkg::AL, 3'd0, 3'd3, 3'd1, 8'd0);
  append_inst(srt_pkg::J,    srt_pkg::LE, 3'd0, 3'd0, 3'd0, 8'd12);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd3, 8'd0);
  append_inst(srt_pkg::DONE, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  for (int k = 1; k <= n_cnt; k++) begin
    expect_store(`SRT_W'(k), `SRT_W'(k));
  end
  load_program();
  start_core();
  wait_done("branch_count_loop", 1'b0);
  compare_stores("branch_count_loop");
endtask

// Subroutine at 5 stores a marker
// Caller then stores the link
task automatic call_and_return();
  logic [`SRT_W-1:0] call_pc;
  call_pc = 16'd1;
  prog_q.delete();
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd4, 3'd0, 3'd0, 8'd3);
  append_inst(srt_pkg::CALL, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd5);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd4, 3'd7, 8'd0);
  append_inst(srt_pkg::DONE, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd5, 3'd0, 3'd0, 8'hA5);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd5, 3'd5, 8'd0);
  append_inst(srt_pkg::RET,  srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  expect_store(16'h00A5, 16'h00A5);
  expect_store(16'd3, call_pc + 16'd1);
  load_program();
  start_core();
  wait_done("call_and_return", 1'b0);
  compare_stores("call_and_return");
endtask

// Three pushes and three pops
// First POP right behind the last PUSH
task automatic stack_reverse_order();
  logic [`SRT_W-1:0] vals [3];
  vals[0] = 16'd11;
  vals[1] = 16'd22;
  vals[2] = 16'd33;
  prog_q.delete();
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd1, 3'd0, 3'd0, 8'd11);
  append_inst(srt_pkg::PUSH, srt_pkg::AL, 3'd0, 3'd0, 3'd1, 8'd0);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd2, 3'd0, 3'd0, 8'd22);
  append_inst(srt_pkg::PUSH, srt_pkg::AL, 3'd0, 3'd0, 3'd2, 8'd0);
  append_inst(srt_pkg::ADDI, srt_pkg::AL, 3'd3, 3'd0, 3'd0, 8'd33);
  append_inst(srt_pkg::PUSH, srt_pkg::AL, 3'd0, 3'd0, 3'd3, 8'd0);
  append_inst(srt_pkg::POP,  srt_pkg::AL, 3'd4, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::POP,  srt_pkg::AL, 3'd5, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::POP,  srt_pkg::AL, 3'd6, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd4, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd5, 8'd0);
  append_inst(srt_pkg::ST,   srt_pkg::AL, 3'd0, 3'd0, 3'd6, 8'd0);
  append_inst(srt_pkg::DONE, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  // Last pushed comes back first
  for (int i = 2; i >= 0; i--) begin
    expect_store(16'd0, vals[i]);
  end
  load_program();
  start_core();
  wait_done("stack_reverse_order", 1'b0);
  compare_stores("stack_reverse_order");
endtask

// AWAIT holds the pipe until bank_ready
// DONE releases the bank
task automatic await_and_done();
  int   hold_cycles;
  int   cycles;
  logic seen;
  hold_cycles = 20;
  cycles      = 0;
  seen        = 1'b0;
  @(posedge clk);
  #DRIVE_DLY bank_ready = 1'b0;
  prog_q.delete();
  append_inst(srt_pkg::ADDI,  srt_pkg::AL, 3'd1, 3'd0, 3'd0, 8'h21);
  append_inst(srt_pkg::AWAIT, srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  append_inst(srt_pkg::ST,    srt_pkg::AL, 3'd0, 3'd1, 3'd1, 8'd0);
  append_inst(srt_pkg::ADDI,  srt_pkg::AL, 3'd2, 3'd1, 3'd0, 8'd1);
  append_inst(srt_pkg::ST,    srt_pkg::AL, 3'd0, 3'd2, 3'd2, 8'd0);
  append_inst(srt_pkg::DONE,  srt_pkg::AL, 3'd0, 3'd0, 3'd0, 8'd0);
  expect_store(16'h0021, 16'h0021);
  expect_store(16'h0022, 16'h0022);
  load_program();
  start_core();
  repeat (hold_cycles) begin
    @(negedge clk);
    check_eq(bank_sorting, 1'b0, "bank_sorting while bank not ready");
    check_eq(srt_wr_en, 1'b0, "srt_wr_en while bank not ready");
    check_eq(busy, 1'b1, "busy while bank not ready");
  end
  @(posedge clk);
  #DRIVE_DLY bank_ready = 1'b1;
  while (!seen && cycles < RUN_LIMIT) begin
    @(negedge clk);
    seen = bank_sorting;
    cycles++;
  end
  assert (seen) else begin
    report_problem("await_and_done: bank_sorting never rose after bank_ready");
  end
  if (seen) begin
    // Stores only follow the bank hand-over
    check_eq(wr_addr_q.size(), 0, "stores before bank_sorting");
  end
  wait_done("await_and_done", 1'b1);
  compare_stores("await_and_done");
endtask

`endif

//--- dv/srt_tb.sv
/* Testbench for the sort-engine sequencer core
   Loads microcode per test, runs it and checks the bank write port */
`timescale 1ns/1ps
`include "srt_settings.svh"

module srt_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int DRIVE_DLY       = 1;
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 2000;
  // Cycle limit for any single wait inside a test
  localparam int RUN_LIMIT       = 1000;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 prog_we;
  logic [`SRT_PC_W-1:0] prog_addr;
  srt_pkg::inst_t       prog_data;
  logic                 start;
  logic                 bank_ready;
  logic [`SRT_W-1:0]    bank_n;
  logic                 busy;
  logic                 done;
  logic                 bank_sorting;
  logic                 srt_wr_en;
  logic [`SRT_W-1:0]    srt_wr_addr;
  logic [`SRT_W-1:0]    srt_wr_data;

  // Program under construction and captured/expected stores
  srt_pkg::inst_t       prog_q [$];
  logic [`SRT_W-1:0]    wr_addr_q [$];
  logic [`SRT_W-1:0]    wr_data_q [$];
  logic [`SRT_W-1:0]    exp_addr_q [$];
  logic [`SRT_W-1:0]    exp_data_q [$];

  int seed           = 32'h8a8c;
  int check_count    = 0;
  int mismatch_count = 0;
  int other_count    = 0;

  srt_core srt_core_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .start        (start),
    .bank_ready   (bank_ready),
    .bank_n       (bank_n),
    .busy         (busy),
    .done         (done),
    .bank_sorting (bank_sorting),
    .srt_wr_en    (srt_wr_en),
    .srt_wr_addr  (srt_wr_addr),
    .srt_wr_data  (srt_wr_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Store monitor for every bank write pulse
  always @(negedge clk) begin
    if (arst_n && srt_wr_en) begin
      wr_addr_q.push_back(srt_wr_addr);
      wr_data_q.push_back(srt_wr_data);
    end
  end

  // Watchdog over the whole run
  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Error at %0t ns: watchdog expired before the tests finished", $time);
    $display("Something failed");
    $finish;
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    assert (got === exp) else begin
      mismatch_count++;
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    other_count++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // Builds one instruction word and appends it to the program
  task automatic append_inst(input srt_pkg::opcode_e op, input srt_pkg::cc_e cc,
                             input srt_pkg::reg_t dst, input srt_pkg::reg_t src0,
                             input srt_pkg::reg_t src1, input logic [`SRT_IMM_W-1:0] imm);
    srt_pkg::inst_t inst;
    inst.opcode = op;
    inst.cc     = cc;
    inst.dst    = dst;
    inst.src0   = src0;
    inst.src1   = src1;
    inst.imm    = imm;
    prog_q.push_back(inst);
  endtask

  task automatic expect_store(input logic [`SRT_W-1:0] addr, input logic [`SRT_W-1:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  // Writes prog_q into the microcode store from address 0
  task automatic load_program();
    foreach (prog_q[i]) begin
      @(posedge clk);
      #DRIVE_DLY;
      prog_we   = 1'b1;
      prog_addr = `SRT_PC_W'(i);
      prog_data = prog_q[i];
    end
    @(posedge clk);
    #DRIVE_DLY;
    prog_we = 1'b0;
  endtask

  task automatic start_core();
    @(posedge clk);
    #DRIVE_DLY start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY start = 1'b0;
    check_eq(busy, 1'b1, "busy after start");
  endtask

  // Waits for the done pulse while busy and bank_sorting hold
  // Then checks the levels that fall with it
  task automatic wait_done(input string what, input logic sorting);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RUN_LIMIT) begin
      @(negedge clk);
      seen = done;
      cycles++;
      if (!seen) begin
        check_eq(busy, 1'b1, $sformatf("%s: busy before done", what));
        check_eq(bank_sorting, sorting, $sformatf("%s: bank_sorting before done", what));
      end
    end
    assert (seen) else begin
      report_problem($sformatf("%s: done did not pulse within %0d cycles", what, RUN_LIMIT));
    end
    if (seen) begin
      check_eq(busy, 1'b0, $sformatf("%s: busy with done", what));
      check_eq(bank_sorting, 1'b0, $sformatf("%s: bank_sorting with done", what));
      @(negedge clk);
      check_eq(done, 1'b0, $sformatf("%s: done one cycle wide", what));
    end
  endtask

  task automatic compare_stores(input string what);
    int n;
    check_eq(wr_addr_q.size(), exp_addr_q.size(), $sformatf("%s: store count", what));
    n = (wr_addr_q.size() < exp_addr_q.size()) ? wr_addr_q.size() : exp_addr_q.size();
    for (int i = 0; i < n; i++) begin
      check_eq(wr_addr_q[i], exp_addr_q[i], $sformatf("%s: store %0d addr", what, i));
      check_eq(wr_data_q[i], exp_data_q[i], $sformatf("%s: store %0d data", what, i));
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  `include "srt_tests.svh"

  initial begin
    arst_n     = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    start      = 1'b0;
    bank_ready = 1'b1;
    bank_n     = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY arst_n = 1'b1;

    check_reset_idle();
    alu_forwarding();
    branch_count_loop();
    call_and_return();
    stack_reverse_order();
    await_and_done();

    repeat (4) @(posedge clk);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             check_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+common
+incdir+dv
common/srt_pkg.sv
common/srt_fe_if.sv
common/srt_stack_if.sv
verilog/srt_fetch.sv
exec/srt_decoder.sv
exec/srt_regfile.sv
exec/srt_exec.sv
verilog/srt_stack.sv
verilog/srt_core.sv
dv/srt_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module srt_tb -o srt_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/srt_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
fi
exit 1
